// File: logic/coco_bus_pkg.sv
// color computer bus definitions
package coco_bus_pkg;

  localparam int ADDR_W   = 16;
  localparam int DATA_W   = 8;
  localparam int RAM_AW   = 15;  // 32 KB ram
  localparam int ROM_AW   = 14;  // 16 KB per rom image
  localparam int REGION_W = 3;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [ROM_AW-1:0]   rom_addr_t;
  typedef logic [RAM_AW-1:0]   ram_addr_t;
  typedef logic [REGION_W-1:0] region_t;

  // region codes
  localparam region_t RAM     = 3'd0;
  localparam region_t SYS_ROM = 3'd1;
  localparam region_t CART    = 3'd2;
  localparam region_t PIA0    = 3'd3;
  localparam region_t PIA1    = 3'd4;
  localparam region_t NONE    = 3'd5;  // old disk i/o space and above

  // last address of each window
  localparam addr_t RAM_END     = 16'h7FFF;
  localparam addr_t SYS_ROM_END = 16'hBFFF;
  localparam addr_t CART_END    = 16'hFEFF;
  localparam addr_t PIA0_END    = 16'hFF1F;
  localparam addr_t PIA1_END    = 16'hFF3F;

  localparam data_t UNMAPPED_DATA = 8'hFF;  // floating bus

  // download port image select
  localparam logic DL_SYS_ROM = 1'b0;
  localparam logic DL_CART    = 1'b1;

  // pia register offsets, mirrored through each window
  localparam logic [1:0] PIA_REG_DATA_A = 2'd0;
  localparam logic [1:0] PIA_REG_CTRL_A = 2'd1;
  localparam logic [1:0] PIA_REG_DATA_B = 2'd2;
  localparam logic [1:0] PIA_REG_CTRL_B = 2'd3;

  localparam int CTRL_DATA_SEL_BIT = 2;  // 0 = direction, 1 = data
  localparam int SND_BIT           = 1;  // pia1 port b single bit sound

endpackage

// File: logic/bus_req_if.sv
// decoded bus request
`timescale 1ns/1ps

interface bus_req_if;
  import coco_bus_pkg::*;

  logic    valid;   // one cycle per transfer
  logic    write;
  region_t region;
  addr_t   offset;  // relative to region base
  data_t   wdata;

  modport src (
    output valid,
    output write,
    output region,
    output offset,
    output wdata
  );

  modport dst (
    input valid,
    input write,
    input region,
    input offset,
    input wdata
  );

endinterface

// File: logic/download_if.sv
// rom image download port
`timescale 1ns/1ps

interface download_if;
  import coco_bus_pkg::*;

  logic      wr;
  logic      index;  // selects system rom or cartridge
  rom_addr_t addr;
  data_t     data;

  modport host (output wr, output index, output addr, output data);
  modport mem  (input wr, input index, input addr, input data);

endinterface

// File: logic/addr_decode.sv
// apb setup capture and address decode
`timescale 1ns/1ps

module addr_decode (
  input  logic                clk,
  input  logic                reset_n,
  input  coco_bus_pkg::addr_t paddr,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  coco_bus_pkg::data_t pwdata,
  bus_req_if.src              req
);
  import coco_bus_pkg::*;

  logic    setup_phase;
  region_t region_d;
  addr_t   offset_d;

  assign setup_phase = psel & ~penable;

  // windows are contiguous, so each base is the previous end plus one
  always_comb
  begin
    if (paddr <= RAM_END)
    begin
      region_d = RAM;
      offset_d = paddr;
    end
    else if (paddr <= SYS_ROM_END)
    begin
      region_d = SYS_ROM;
      offset_d = paddr - (RAM_END + 16'd1);
    end
    else if (paddr <= CART_END)
    begin
      region_d = CART;
      offset_d = paddr - (SYS_ROM_END + 16'd1);
    end
    else if (paddr <= PIA0_END)
    begin
      region_d = PIA0;
      offset_d = paddr - (CART_END + 16'd1);
    end
    else if (paddr <= PIA1_END)
    begin
      region_d = PIA1;
      offset_d = paddr - (PIA0_END + 16'd1);
    end
    else
    begin
      region_d = NONE;  // nothing answers up here
      offset_d = paddr - (PIA1_END + 16'd1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
      req.valid <= 1'b0;
    else
      req.valid <= setup_phase;  // one pulse, penable follows
  end

  always_ff @(posedge clk)
  begin
    if (setup_phase)
    begin
      req.write  <= pwrite;
      req.region <= region_d;
      req.offset <= offset_d;
      req.wdata  <= pwdata;
    end
  end

endmodule

// File: logic/mem_access.sv
// ram and rom image access stage
`timescale 1ns/1ps

module mem_access (
  input  logic                clk,
  input  logic                reset_n,
  bus_req_if.dst              req_in,
  bus_req_if.src              req_out,
  download_if.mem             dl,
  output coco_bus_pkg::data_t mem_rdata
);
  import coco_bus_pkg::*;

  data_t ram      [0:(1 << RAM_AW)-1];
  data_t sys_rom  [0:(1 << ROM_AW)-1];
  data_t cart_rom [0:(1 << ROM_AW)-1];

  ram_addr_t ram_addr;
  rom_addr_t rom_addr;
  logic      ram_we;
  logic      rd_en;

  assign ram_addr = req_in.offset[RAM_AW-1:0];
  assign rom_addr = req_in.offset[ROM_AW-1:0];

  // rom windows ignore cpu side writes
  assign ram_we = req_in.valid && req_in.write && (req_in.region == RAM);
  assign rd_en  = req_in.valid && !req_in.write;

  always_ff @(posedge clk)
  begin
    if (ram_we)
      ram[ram_addr] <= req_in.wdata;
  end

  // download side, independent of apb traffic
  always_ff @(posedge clk)
  begin
    if (dl.wr && (dl.index == DL_SYS_ROM))
      sys_rom[dl.addr] <= dl.data;
  end

  always_ff @(posedge clk)
  begin
    if (dl.wr && (dl.index == DL_CART))
      cart_rom[dl.addr] <= dl.data;
  end

  always_ff @(posedge clk)
  begin
    if (rd_en)
    begin
      case (req_in.region)
        RAM:     mem_rdata <= ram[ram_addr];
        SYS_ROM: mem_rdata <= sys_rom[rom_addr];
        CART:    mem_rdata <= cart_rom[rom_addr];
        default: mem_rdata <= UNMAPPED_DATA;  // pia and unmapped muxed later
      endcase
    end
  end

  // stage 2 copy of the request
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      req_out.valid <= 1'b0;
    else
      req_out.valid <= req_in.valid;
  end

  always_ff @(posedge clk)
  begin
    if (req_in.valid)
    begin
      req_out.write  <= req_in.write;
      req_out.region <= req_in.region;
      req_out.offset <= req_in.offset;
      req_out.wdata  <= req_in.wdata;
    end
  end

endmodule

// File: logic/pia_regs.sv
// simplified pia register file
`timescale 1ns/1ps

module pia_regs (
  input  logic                  clk,
  input  logic                  reset_n,
  bus_req_if.dst                req,
  input  coco_bus_pkg::region_t sel,
  input  coco_bus_pkg::data_t   porta_in,
  output coco_bus_pkg::data_t   portb_out,
  output coco_bus_pkg::data_t   rdata
);
  import coco_bus_pkg::*;

  data_t      ddr_a;
  data_t      ctrl_a;
  data_t      ddr_b;
  data_t      data_b;
  data_t      ctrl_b;
  data_t      portb_pins;
  data_t      rdata_d;
  logic       hit;
  logic       wr_en;
  logic [1:0] reg_sel;

  assign hit     = req.valid && (req.region == sel);
  assign wr_en   = hit && req.write;
  assign reg_sel = req.offset[1:0];  // registers mirror every 4 bytes

  assign portb_out  = data_b & ddr_b;  // inputs read as 0 on the pins
  assign portb_pins = portb_out;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      ddr_a  <= '0;
      ctrl_a <= '0;
      ddr_b  <= '0;
      data_b <= '0;
      ctrl_b <= '0;
    end
    else if (wr_en)
    begin
      case (reg_sel)
        PIA_REG_DATA_A: if (!ctrl_a[CTRL_DATA_SEL_BIT]) ddr_a <= req.wdata;  // port a is input only
        PIA_REG_CTRL_A: ctrl_a <= req.wdata;
        PIA_REG_DATA_B:
          if (ctrl_b[CTRL_DATA_SEL_BIT])
            data_b <= req.wdata;
          else
            ddr_b <= req.wdata;
        PIA_REG_CTRL_B: ctrl_b <= req.wdata;
        default: ;
      endcase
    end
  end

  always_comb
  begin
    case (reg_sel)
      PIA_REG_DATA_A: rdata_d = ctrl_a[CTRL_DATA_SEL_BIT] ? porta_in : ddr_a;
      PIA_REG_CTRL_A: rdata_d = ctrl_a;
      PIA_REG_DATA_B:
        rdata_d = ctrl_b[CTRL_DATA_SEL_BIT] ?
                  ((data_b & ddr_b) | (portb_pins & ~ddr_b)) : ddr_b;
      default:        rdata_d = ctrl_b;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (hit && !req.write)
      rdata <= rdata_d;
  end

endmodule

// File: logic/read_return.sv
// read data select and apb completion
`timescale 1ns/1ps

module read_return (
  bus_req_if.dst              req,
  input  coco_bus_pkg::data_t mem_rdata,
  input  coco_bus_pkg::data_t pia0_rdata,
  input  coco_bus_pkg::data_t pia1_rdata,
  output coco_bus_pkg::data_t prdata,
  output logic                pready
);
  import coco_bus_pkg::*;

  // stage 2 valid marks the second access cycle
  assign pready = req.valid;

  always_comb
  begin
    if (req.write)
      prdata = UNMAPPED_DATA;
    else
    begin
      case (req.region)
        RAM,
        SYS_ROM,
        CART:    prdata = mem_rdata;
        PIA0:    prdata = pia0_rdata;
        PIA1:    prdata = pia1_rdata;
        default: prdata = UNMAPPED_DATA;  // above ff3f
      endcase
    end
  end

endmodule

// File: logic/coco_bus_top.sv
// color computer system bus
`timescale 1ns/1ps

module coco_bus_top (
  input  logic                    clk,
  input  logic                    reset_n,
  input  coco_bus_pkg::addr_t     paddr,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  coco_bus_pkg::data_t     pwdata,
  output coco_bus_pkg::data_t     prdata,
  output logic                    pready,
  input  logic                    dl_wr,
  input  logic                    dl_index,
  input  coco_bus_pkg::rom_addr_t dl_addr,
  input  coco_bus_pkg::data_t     dl_data,
  input  coco_bus_pkg::data_t     kb_rows,
  input  logic                    casdout,
  output coco_bus_pkg::data_t     kb_cols,
  output coco_bus_pkg::data_t     pia1_portb,
  output logic                    sndout
);
  import coco_bus_pkg::*;

  bus_req_if  req_s1 ();
  bus_req_if  req_s2 ();
  download_if dl_bus ();

  data_t mem_rdata;
  data_t pia0_rdata;
  data_t pia1_rdata;

  assign dl_bus.wr    = dl_wr;
  assign dl_bus.index = dl_index;
  assign dl_bus.addr  = dl_addr;
  assign dl_bus.data  = dl_data;

  addr_decode u_addr_decode (
    .clk     (clk),
    .reset_n (reset_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .req     (req_s1)
  );

  mem_access u_mem_access (
    .clk       (clk),
    .reset_n   (reset_n),
    .req_in    (req_s1),
    .req_out   (req_s2),
    .dl        (dl_bus),
    .mem_rdata (mem_rdata)
  );

  // keyboard pia, rows in and columns out
  pia_regs pia0 (
    .clk       (clk),
    .reset_n   (reset_n),
    .req       (req_s1),
    .sel       (PIA0),
    .porta_in  (kb_rows),
    .portb_out (kb_cols),
    .rdata     (pia0_rdata)
  );

  pia_regs pia1 (
    .clk       (clk),
    .reset_n   (reset_n),
    .req       (req_s1),
    .sel       (PIA1),
    .porta_in  ({7'd0, casdout}),  // cassette data on bit 0
    .portb_out (pia1_portb),
    .rdata     (pia1_rdata)
  );

  read_return u_read_return (
    .req        (req_s2),
    .mem_rdata  (mem_rdata),
    .pia0_rdata (pia0_rdata),
    .pia1_rdata (pia1_rdata),
    .prdata     (prdata),
    .pready     (pready)
  );

  assign sndout = pia1_portb[SND_BIT];  // one bit sound

endmodule

// File: tests/coco_bus_assertions.sv
// bus protocol checks
`timescale 1ns/1ps

module coco_bus_assertions (
  input logic                clk,
  input logic                reset_n,
  input logic                psel,
  input logic                penable,
  input logic                pready,
  input coco_bus_pkg::data_t pia1_portb,
  input logic                sndout
);

  int assert_fails = 0;  // failure tally

  // quiet bus through reset and one cycle past it
  ready_low_in_reset: assert property (@(posedge clk) !reset_n |=> !pready)
    else
    begin
      assert_fails++;
      $error("pready high during reset or in the first cycle after it");
    end

  ready_needs_access: assert property (@(posedge clk) disable iff (!reset_n)
    pready |-> (psel && penable))
    else
    begin
      assert_fails++;
      $error("pready high outside an access phase");
    end

  // fixed two cycle access phase
  no_ready_first_cycle: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(penable) |-> !pready)
    else
    begin
      assert_fails++;
      $error("pready high in the first access cycle");
    end

  ready_second_cycle: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(penable) |=> pready)
    else
    begin
      assert_fails++;
      $error("pready missing in the second access cycle");
    end

  // sound is wired to port b bit 1
  snd_follows_portb: assert property (@(posedge clk) disable iff (!reset_n)
    sndout == pia1_portb[1])
    else
    begin
      assert_fails++;
      $error("sndout differs from pia1 port b bit 1");
    end

endmodule

bind coco_bus_top coco_bus_assertions bus_checks (
  .clk        (clk),
  .reset_n    (reset_n),
  .psel       (psel),
  .penable    (penable),
  .pready     (pready),
  .pia1_portb (pia1_portb),
  .sndout     (sndout)
);

// File: tests/tb_coco_bus.sv
// coco bus testbench
`timescale 1ns/1ps

module tb_coco_bus;
  import coco_bus_pkg::*;

  localparam int MAX_CYCLES = 4000;  // about 1600 cycles of traffic, with margin

  logic      clk;
  logic      reset_n;
  addr_t     paddr;
  logic      psel;
  logic      penable;
  logic      pwrite;
  data_t     pwdata;
  data_t     prdata;
  logic      pready;
  logic      dl_wr;
  logic      dl_index;
  rom_addr_t dl_addr;
  data_t     dl_data;
  data_t     kb_rows;
  logic      casdout;
  data_t     kb_cols;
  data_t     pia1_portb;
  logic      sndout;

  // reference model of memories and pia registers
  data_t ram_model  [0:32767];
  data_t sys_model  [0:16383];
  data_t cart_model [0:16383];
  data_t ddr_a  [0:1];
  data_t ctrl_a [0:1];
  data_t ddr_b  [0:1];
  data_t data_b [0:1];
  data_t ctrl_b [0:1];

  int          mismatches;
  int          assert_fails;
  int          cycles;
  logic [31:0] rnd;
  addr_t       ram_addrs [0:63];
  rom_addr_t   sys_offs  [0:31];
  rom_addr_t   cart_offs [0:31];
  data_t       dir_v;
  data_t       data_v;

  coco_bus_top DUT (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic void model_write(addr_t addr, data_t data);
    logic p;
    p = addr[5];  // ff20 window is pia1
    if (addr <= 16'h7FFF)
      ram_model[addr[14:0]] = data;
    else if (addr >= 16'hFF00 && addr <= 16'hFF3F)
    begin
      case (addr[1:0])
        2'd0: if (!ctrl_a[p][2]) ddr_a[p] = data;
        2'd1: ctrl_a[p] = data;
        2'd2:
          if (ctrl_b[p][2])
            data_b[p] = data;
          else
            ddr_b[p] = data;
        default: ctrl_b[p] = data;
      endcase
    end
  endfunction

  function automatic data_t expected_read(addr_t addr);
    logic  p;
    data_t pins;
    data_t porta;
    p     = addr[5];
    pins  = data_b[p] & ddr_b[p];
    porta = p ? {7'b0, casdout} : kb_rows;
    if (addr <= 16'h7FFF)
      return ram_model[addr[14:0]];
    else if (addr <= 16'hBFFF)
      return sys_model[addr[13:0]];
    else if (addr <= 16'hFEFF)
      return cart_model[addr[13:0]];  // c000 base, low bits are the offset
    else if (addr <= 16'hFF3F)
    begin
      case (addr[1:0])
        2'd0: return ctrl_a[p][2] ? porta : ddr_a[p];
        2'd1: return ctrl_a[p];
        2'd2: return ctrl_b[p][2] ? ((data_b[p] & ddr_b[p]) | (pins & ~ddr_b[p])) : ddr_b[p];
        default: return ctrl_b[p];
      endcase
    end
    return 8'hFF;
  endfunction

  function automatic void check_byte(string name, data_t exp, data_t act);
    assert (act === exp)
    else
    begin
      mismatches++;
      $display("MISMATCH %s: expected %02h, actual %02h", name, exp, act);
    end
  endfunction

  // setup cycle, access until pready, then back to idle
  task automatic apb_transfer(input addr_t addr, input logic wr, input data_t wdata,
                              output data_t rdata);
    @(negedge clk);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    do
      @(negedge clk);
    while (!pready);
    rdata = prdata;  // held until the completing edge
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input addr_t addr, input data_t data);
    data_t unused;
    apb_transfer(addr, 1'b1, data, unused);
    model_write(addr, data);
  endtask

  task automatic apb_read(input addr_t addr, output data_t data);
    apb_transfer(addr, 1'b0, 8'h00, data);
  endtask

  task automatic read_check(input string name, input addr_t addr);
    data_t exp;
    data_t got;
    exp = expected_read(addr);
    apb_read(addr, got);
    check_byte(name, exp, got);
  endtask

  task automatic dl_write(input logic index, input rom_addr_t addr, input data_t data);
    @(negedge clk);
    dl_wr    = 1'b1;
    dl_index = index;
    dl_addr  = addr;
    dl_data  = data;
    @(negedge clk);
    dl_wr = 1'b0;
    if (index)
      cart_model[addr] = data;
    else
      sys_model[addr] = data;
  endtask

  initial
  begin
    rnd        = $urandom(32'h65ab);
    mismatches = 0;
    cycles     = 0;
    reset_n    = 1'b0;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    dl_wr      = 1'b0;
    dl_index   = 1'b0;
    dl_addr    = '0;
    dl_data    = '0;
    kb_rows    = '0;
    casdout    = 1'b0;
    for (int p = 0; p < 2; p++)
    begin
      ddr_a[p]  = '0;
      ctrl_a[p] = '0;
      ddr_b[p]  = '0;
      data_b[p] = '0;
      ctrl_b[p] = '0;
    end
    repeat (4) @(negedge clk);
    reset_n = 1'b1;

    check_byte("reset kb_cols", 8'h00, kb_cols);
    check_byte("reset pia1_portb", 8'h00, pia1_portb);
    check_byte("reset sndout", 8'h00, {7'b0, sndout});

    for (int i = 0; i < 64; i++)
    begin
      rnd = $urandom;
      ram_addrs[i] = {1'b0, rnd[14:0]};
      apb_write(ram_addrs[i], rnd[23:16]);
    end
    for (int i = 0; i < 64; i++)
      read_check("ram", ram_addrs[i]);

    for (int i = 0; i < 32; i++)
    begin
      rnd = $urandom;
      sys_offs[i]  = rnd[13:0];
      cart_offs[i] = {1'b0, rnd[26:14]};  // stays below the pia windows
      dl_write(1'b0, sys_offs[i], rnd[7:0]);
      rnd = $urandom;
      dl_write(1'b1, cart_offs[i], rnd[7:0]);
    end
    for (int i = 0; i < 32; i++)
    begin
      read_check("sys rom", {2'b10, sys_offs[i]});
      read_check("cart rom", {2'b11, cart_offs[i]});
      apb_write({2'b10, sys_offs[i]}, ~expected_read({2'b10, sys_offs[i]}));
      apb_write({2'b11, cart_offs[i]}, ~expected_read({2'b11, cart_offs[i]}));
      read_check("sys rom after write", {2'b10, sys_offs[i]});
      read_check("cart rom after write", {2'b11, cart_offs[i]});
    end

    for (int i = 0; i < 4; i++)
    begin
      rnd    = $urandom;
      dir_v  = (i < 2) ? 8'hFF : rnd[7:0];
      data_v = (i == 0) ? 8'h02 : rnd[15:8];
      apb_write(16'hFF23, 8'h00);
      apb_write(16'hFF22, dir_v);
      apb_write(16'hFF23, 8'h04);
      apb_write(16'hFF22, data_v);
      check_byte("pia1 portb pins", data_v & dir_v, pia1_portb);
      check_byte("sndout", {7'b0, data_v[1] & dir_v[1]}, {7'b0, sndout});
      read_check("pia1 portb read", 16'hFF22);
    end

    apb_write(16'hFF01, 8'h04);
    apb_write(16'hFF21, 8'h04);
    read_check("pia0 ctrl a", 16'hFF01);
    for (int i = 0; i < 8; i++)
    begin
      rnd     = $urandom;
      kb_rows = rnd[7:0];  // still at a falling edge here
      casdout = rnd[8];
      read_check("pia0 port a", 16'hFF00);
      read_check("pia1 port a", 16'hFF20);
    end
    apb_write(16'hFF03, 8'h00);
    apb_write(16'hFF02, 8'hFF);
    apb_write(16'hFF03, 8'h04);
    for (int i = 0; i < 4; i++)
    begin
      rnd = $urandom;
      apb_write(16'hFF02, rnd[7:0]);
      check_byte("kb_cols", rnd[7:0], kb_cols);
    end

    read_check("unmapped ff40", 16'hFF40);
    read_check("unmapped ffff", 16'hFFFF);
    apb_write(16'hFF40, 8'h00);
    read_check("unmapped ff40 after write", 16'hFF40);

    repeat (2) @(negedge clk);
    assert_fails = DUT.bus_checks.assert_fails;
    $display("summary: %0d mismatches, %0d assertion failures", mismatches, assert_fails);
    if (mismatches == 0 && assert_fails == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// File: build.f
logic/coco_bus_pkg.sv
logic/bus_req_if.sv
logic/download_if.sv
logic/addr_decode.sv
logic/mem_access.sv
logic/pia_regs.sv
logic/read_return.sv
logic/coco_bus_top.sv
tests/coco_bus_assertions.sv
tests/tb_coco_bus.sv

// File: run_sim.sh
#!/bin/sh
# compile with verilator, run, then search the log for the fail message
verilator --binary --timing --assert --top-module tb_coco_bus -Mdir obj_dir -f build.f \
  || { echo "build failed"; exit 1; }
./obj_dir/Vtb_coco_bus +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
! grep -q "Done: errors found" sim.log && grep -q "Done: no errors" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
